// File: design/mandel_pkg.sv
/* mandelbrot renderer shared definitions
   fixed-point format, reset view, framebuffer geometry and pixel types */

package mandel_pkg;

    // fixed-point format, signed 4.21
    localparam int FP_WIDTH = 25;
    localparam int FP_INT   = 4;
    localparam int FP_FRAC  = FP_WIDTH - FP_INT;  // 21

    typedef logic signed [FP_WIDTH-1:0] fp_t;

    // escape test threshold on |z|^2
    localparam fp_t ESCAPE_SQ = fp_t'(4 * (1 << FP_FRAC));

    localparam int ITER_MAX = 31;  // iteration cap

    localparam int CIDX_W = 8;
    typedef logic [CIDX_W-1:0] cidx_t;

    // small framebuffer keeps sim short
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 18;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = $clog2(FB_PIXELS);
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

    localparam int CORD_W = 6;
    typedef logic [CORD_W-1:0] cord_t;

    // reset view
    localparam fp_t X_START    = fp_t'(-7 * (1 << (FP_FRAC - 1)));  // -3.5
    localparam fp_t Y_START    = fp_t'(-9 * (1 << (FP_FRAC - 3)));  // -1.125
    localparam fp_t STEP_START = fp_t'(1 << (FP_FRAC - 3));        // 1/8, also the coarsest step

    localparam int PAN_SHIFT = 2;  // pan by 4 steps

    typedef struct packed {
        fp_t x_start;  // left edge
        fp_t y_start;  // top edge
        fp_t step;     // per-pixel increment
    } view_t;

    typedef struct packed {
        cord_t x;
        cord_t y;
        cidx_t cidx;  // escape count as colour index
    } pixel_t;

    typedef enum logic [1:0] {PAN_X, PAN_Y, ZOOM} view_mode_t;

endpackage

// File: design/view_control.sv
/* view controller
   button strobes pick a mode and build a candidate view,
   valid candidates are committed and start a render */

`timescale 1ns/1ps

module view_control import mandel_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       btn_fire,
    input  logic       btn_up,
    input  logic       btn_dn,
    input  logic       busy,      // render in progress
    output view_mode_t mode,
    output view_t      view,      // view being rendered
    output logic       render_start
);

    view_t cand;        // registered candidate
    view_t cand_next;
    logic  pending;     // candidate waiting for check
    logic  render_req;  // initial render after reset
    logic  accept;
    logic  cand_ok;

    // up/down only when idle and nothing in flight
    assign accept  = !busy && !pending && !render_start && !render_req;
    assign cand_ok = (cand.step != '0) && (cand.step <= STEP_START);

    // apply pan/zoom rules to the current view
    always_comb begin
        cand_next = view;
        case (mode)
            PAN_X: begin
                if (btn_up) cand_next.x_start = view.x_start - (view.step <<< PAN_SHIFT);
                else        cand_next.x_start = view.x_start + (view.step <<< PAN_SHIFT);
            end
            PAN_Y: begin
                if (btn_up) cand_next.y_start = view.y_start - (view.step <<< PAN_SHIFT);
                else        cand_next.y_start = view.y_start + (view.step <<< PAN_SHIFT);
            end
            ZOOM: begin
                if (btn_up) begin  // zoom out
                    cand_next.step    = view.step <<< 1;
                    cand_next.x_start = view.x_start - (view.step <<< 4);
                    cand_next.y_start = view.y_start - (view.step <<< 3);
                end else begin     // zoom in
                    cand_next.step    = view.step >>> 1;
                    cand_next.x_start = view.x_start + (view.step <<< 3);
                    cand_next.y_start = view.y_start + (view.step <<< 2);
                end
            end
            default: cand_next = view;
        endcase
    end

    // candidate loaded on an accepted strobe
    always_ff @(posedge clk_sys) begin
        if (accept && (btn_up || btn_dn)) cand <= cand_next;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            mode         <= PAN_X;
            view         <= '{x_start: X_START, y_start: Y_START, step: STEP_START};
            pending      <= 1'b0;
            render_req   <= 1'b1;  // draw reset view
            render_start <= 1'b0;
        end else begin
            render_start <= 1'b0;  // pulse

            // fire is never blocked
            if (btn_fire) begin
                case (mode)
                    PAN_X:   mode <= PAN_Y;
                    PAN_Y:   mode <= ZOOM;
                    default: mode <= PAN_X;
                endcase
            end

            if (accept && (btn_up || btn_dn)) pending <= 1'b1;

            if (pending) begin
                pending <= 1'b0;
                if (cand_ok) begin  // out of range candidates dropped silently
                    view         <= cand;
                    render_start <= 1'b1;
                end
            end else if (render_req) begin
                render_req   <= 1'b0;
                render_start <= 1'b1;
            end
        end
    end

    // busy comes back from the scanner
    a_no_start_busy: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !(render_start && busy));

endmodule

// File: design/pixel_scan.sv
/* pixel scanner
   walks the framebuffer in raster order, one escape calculation at a time */

`timescale 1ns/1ps

module pixel_scan import mandel_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  logic   render_start,
    input  view_t  view,        // stable while busy
    input  logic   iter_done,
    input  cidx_t  iter_count,
    output logic   iter_start,
    output fp_t    c_re,
    output fp_t    c_im,
    output logic   pix_valid,
    output pixel_t pix,
    output logic   busy,
    output logic   render_done
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIN} scan_state_t;

    scan_state_t state;
    cord_t       x_cnt;
    cord_t       y_cnt;
    logic        last_col;
    logic        last_pix;

    assign last_col = (x_cnt == CORD_W'(FB_WIDTH - 1));
    assign last_pix = last_col && (y_cnt == CORD_W'(FB_HEIGHT - 1));

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state       <= S_IDLE;
            busy        <= 1'b0;
            iter_start  <= 1'b0;
            pix_valid   <= 1'b0;
            render_done <= 1'b0;
        end else begin
            iter_start  <= 1'b0;
            pix_valid   <= 1'b0;
            render_done <= 1'b0;
            case (state)
                S_IDLE: if (render_start) begin
                    x_cnt      <= '0;
                    y_cnt      <= '0;
                    c_re       <= view.x_start;  // top left corner
                    c_im       <= view.y_start;
                    busy       <= 1'b1;
                    iter_start <= 1'b1;
                    state      <= S_RUN;
                end
                S_RUN: if (iter_done) begin
                    pix_valid <= 1'b1;
                    pix       <= '{x: x_cnt, y: y_cnt, cidx: iter_count};
                    if (last_pix) begin
                        state <= S_FIN;
                    end else begin
                        iter_start <= 1'b1;  // next pixel straight away
                        if (last_col) begin  // wrap to next row
                            x_cnt <= '0;
                            y_cnt <= y_cnt + 1'b1;
                            c_re  <= view.x_start;
                            c_im  <= c_im + view.step;
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                            c_re  <= c_re + view.step;
                        end
                    end
                end
                S_FIN: begin  // one cycle after the last pixel
                    render_done <= 1'b1;
                    busy        <= 1'b0;
                    state       <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // one calculation in flight at a time
    a_one_outstanding: assert property (@(posedge clk_sys) disable iff (rst_sys)
        iter_start |=> (!iter_start throughout iter_done [->1]));

endmodule

// File: design/mandel_iter.sv
/* escape time engine
   iterates z = z^2 + c in fixed point, one step per cycle,
   and reports how many steps ran before escape or the cap */

`timescale 1ns/1ps

module mandel_iter import mandel_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  iter_start,
    input  fp_t   c_re,
    input  fp_t   c_im,
    output logic  iter_done,
    output cidx_t iter_count
);

    fp_t   z_re;
    fp_t   z_im;
    fp_t   c_re_q;   // c captured at start
    fp_t   c_im_q;
    cidx_t count;
    logic  running;

    // full precision products
    logic signed [2*FP_WIDTH-1:0] prod_re2;
    logic signed [2*FP_WIDTH-1:0] prod_im2;
    logic signed [2*FP_WIDTH-1:0] prod_xy;

    fp_t re2;   // z_re^2
    fp_t im2;   // z_im^2
    fp_t xy;    // z_re * z_im
    logic signed [FP_WIDTH:0] mag;  // one extra bit, sum can reach 8
    logic  escaped;
    logic  capped;

    always_comb begin
        prod_re2 = z_re * z_re;
        prod_im2 = z_im * z_im;
        prod_xy  = z_re * z_im;
        re2      = fp_t'(prod_re2 >>> FP_FRAC);  // back to 4.21, top bits dropped
        im2      = fp_t'(prod_im2 >>> FP_FRAC);
        xy       = fp_t'(prod_xy >>> FP_FRAC);
        mag      = re2 + im2;
    end

    assign escaped = mag > ESCAPE_SQ;
    assign capped  = (count == CIDX_W'(ITER_MAX));

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            running   <= 1'b0;
            iter_done <= 1'b0;
        end else begin
            iter_done <= 1'b0;
            if (iter_start) begin
                z_re    <= '0;  // z0 = 0
                z_im    <= '0;
                count   <= '0;
                c_re_q  <= c_re;
                c_im_q  <= c_im;
                running <= 1'b1;
            end else if (running) begin
                if (escaped || capped) begin
                    iter_done  <= 1'b1;
                    iter_count <= count;
                    running    <= 1'b0;
                end else begin
                    z_re  <= re2 - im2 + c_re_q;
                    z_im  <= (xy <<< 1) + c_im_q;  // 2xy + c_im
                    count <= count + 1'b1;
                end
            end
        end
    end

    // count stops at the cap
    a_count_cap: assert property (@(posedge clk_sys) disable iff (rst_sys)
        iter_done |-> (iter_count <= CIDX_W'(ITER_MAX)));

endmodule

// File: design/framebuffer.sv
/* colour index framebuffer
   pixel to address conversion, registered write, synchronous read */

`timescale 1ns/1ps

module framebuffer import mandel_pkg::*; (
    input  logic     clk_sys,
    input  logic     pix_valid,
    input  pixel_t   pix,
    input  fb_addr_t rd_addr,
    output cidx_t    rd_cidx
);

    cidx_t    mem [FB_PIXELS];

    logic     wr_en;    // write stage, one cycle after pix_valid
    fb_addr_t wr_addr;
    cidx_t    wr_cidx;

    // address stage, row major
    always_ff @(posedge clk_sys) begin
        wr_en   <= pix_valid;
        wr_addr <= fb_addr_t'(pix.y * FB_WIDTH + pix.x);
        wr_cidx <= pix.cidx;
    end

    // memory write lands the cycle after
    always_ff @(posedge clk_sys) begin
        if (wr_en) mem[wr_addr] <= wr_cidx;
    end

    // synchronous read port
    always_ff @(posedge clk_sys) begin
        rd_cidx <= mem[rd_addr];
    end

    // scanner coordinates stay inside the buffer
    a_wr_in_range: assert property (@(posedge clk_sys)
        wr_en |-> (wr_addr < FB_PIXELS));

endmodule

// File: design/mandel_top.sv
/* mandelbrot renderer top level
   view control, pixel scan, escape engine and framebuffer */

`timescale 1ns/1ps

module mandel_top import mandel_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       btn_fire,   // clean one cycle strobes
    input  logic       btn_up,
    input  logic       btn_dn,
    input  fb_addr_t   rd_addr,
    output cidx_t      rd_cidx,
    output view_mode_t mode,
    output logic       busy,
    output logic       render_done
);

    view_t  view;
    logic   render_start;
    logic   iter_start;
    logic   iter_done;
    cidx_t  iter_count;
    fp_t    c_re;
    fp_t    c_im;
    logic   pix_valid;
    pixel_t pix;

    view_control view_control_i (
        .clk_sys, .rst_sys, .btn_fire, .btn_up, .btn_dn,
        .busy, .mode, .view, .render_start
    );

    pixel_scan pixel_scan_i (
        .clk_sys, .rst_sys, .render_start, .view,
        .iter_done, .iter_count, .iter_start, .c_re, .c_im,
        .pix_valid, .pix, .busy, .render_done
    );

    mandel_iter mandel_iter_i (
        .clk_sys, .rst_sys, .iter_start, .c_re, .c_im,
        .iter_done, .iter_count
    );

    framebuffer framebuffer_i (
        .clk_sys, .pix_valid, .pix, .rd_addr, .rd_cidx
    );

endmodule

// File: bench/mandel_ref.svh
/* reference model for the mandelbrot renderer
   mode order, view update rules and a bit-exact escape count */

`ifndef MANDEL_REF_SVH
`define MANDEL_REF_SVH

// fire order PAN_X, PAN_Y, ZOOM, back to PAN_X
function automatic view_mode_t next_mode(view_mode_t m);
    case (m)
        PAN_X:   return PAN_Y;
        PAN_Y:   return ZOOM;
        default: return PAN_X;
    endcase
endfunction

// candidate view for one up or down strobe
function automatic view_t next_view(view_t v, view_mode_t m, bit up);
    view_t n;
    n = v;
    if (m == PAN_X) begin
        if (up) n.x_start = fp_t'(v.x_start - 4 * v.step);  // 4 steps left
        else    n.x_start = fp_t'(v.x_start + 4 * v.step);
    end else if (m == PAN_Y) begin
        if (up) n.y_start = fp_t'(v.y_start - 4 * v.step);
        else    n.y_start = fp_t'(v.y_start + 4 * v.step);
    end else if (up) begin  // zoom out around the centre
        n.step    = fp_t'(2 * v.step);
        n.x_start = fp_t'(v.x_start - 16 * v.step);
        n.y_start = fp_t'(v.y_start - 8 * v.step);
    end else begin          // zoom in
        n.step    = v.step / 2;
        n.x_start = fp_t'(v.x_start + 8 * v.step);
        n.y_start = fp_t'(v.y_start + 4 * v.step);
    end
    return n;
endfunction

function automatic bit view_in_range(view_t v);
    return (v.step != 0) && (v.step <= STEP_START);
endfunction

// z = z^2 + c, products shifted by FP_FRAC and cut to FP_WIDTH
function automatic cidx_t escape_count(fp_t cr, fp_t ci);
    fp_t    zr;
    fp_t    zi;
    fp_t    re2;
    fp_t    im2;
    fp_t    xy;
    longint mag;
    int     n;
    zr = '0;
    zi = '0;
    for (n = 0; n < ITER_MAX; n++) begin
        re2 = fp_t'((longint'(zr) * longint'(zr)) >>> FP_FRAC);
        im2 = fp_t'((longint'(zi) * longint'(zi)) >>> FP_FRAC);
        xy  = fp_t'((longint'(zr) * longint'(zi)) >>> FP_FRAC);
        mag = longint'(re2) + longint'(im2);  // exact sum
        if (mag > 4 * (longint'(1) << FP_FRAC)) return cidx_t'(n);
        zr = fp_t'(re2 - im2 + cr);
        zi = fp_t'(2 * xy + ci);
    end
    return cidx_t'(ITER_MAX);  // never escaped
endfunction

`endif

// File: bench/mandel_tb.sv
/* testbench for the mandelbrot renderer
   drives button strobes, reads the framebuffer back and checks it against the model */

`timescale 1ns/1ps

module mandel_tb import mandel_pkg::*; ();

    `include "mandel_ref.svh"

    logic       clk_sys = 1'b0;
    logic       rst_sys;
    logic       btn_fire;
    logic       btn_up;
    logic       btn_dn;
    fb_addr_t   rd_addr;
    cidx_t      rd_cidx;
    view_mode_t mode;
    logic       busy;
    logic       render_done;

    view_t      exp_view;             // view the model says is on screen
    view_mode_t exp_mode;
    cidx_t      ref_pix [FB_PIXELS];  // model framebuffer
    logic       sweep_on;
    logic       chk_q;                // readback compare enable, aligned with rd_cidx
    cidx_t      exp_q;
    int         err_cnt;
    int         err_mark;
    int         test_cnt;
    int         test_fail;
    int         seed;
    int         wait_n;
    int         k;
    bit         seen;

    mandel_top mandel_top_i (
        .clk_sys, .rst_sys, .btn_fire, .btn_up, .btn_dn,
        .rd_addr, .rd_cidx, .mode, .busy, .render_done
    );

    always #5 clk_sys = ~clk_sys;

    // model value for the address the DUT just latched
    always @(posedge clk_sys) begin
        chk_q <= sweep_on;
        exp_q <= ref_pix[rd_addr];
    end

    a_readback: assert property (@(negedge clk_sys) chk_q |-> (rd_cidx == exp_q))
        else begin
            err_cnt++;
            $display("error %0t rd_cidx got %0d expected %0d", $time, rd_cidx, exp_q);
        end

    a_done_idle: assert property (@(negedge clk_sys) disable iff (rst_sys)
        render_done |-> !busy)
        else begin
            err_cnt++;
            $display("render_done pulsed at %0t while busy was still high", $time);
        end

    task automatic pulse(input logic f, input logic u, input logic d);
        btn_fire = f;
        btn_up   = u;
        btn_dn   = d;
        @(negedge clk_sys);  // one cycle wide
        btn_fire = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
    endtask

    task automatic wait_busy(input int limit, output bit rose);
        int n;
        rose = 1'b0;
        for (n = 0; n < limit && !rose; n++) begin
            @(negedge clk_sys);
            rose = busy;
        end
    endtask

    task automatic wait_done(output bit done);
        int n;
        done = 1'b0;
        for (n = 0; n < FB_PIXELS * (ITER_MAX + 4) && !done; n++) begin  // worst case render
            @(negedge clk_sys);
            done = render_done;
        end
        assert (done) else begin
            err_cnt++;
            $display("render_done did not arrive before the timeout at %0t", $time);
        end
    endtask

    task automatic fire_and_check();
        pulse(1'b1, 1'b0, 1'b0);
        exp_mode = next_mode(exp_mode);
        assert (mode == exp_mode) else begin
            err_cnt++;
            $display("error %0t mode got %s expected %s", $time, mode.name(), exp_mode.name());
        end
    endtask

    // model takes the strobe first, rejected views leave exp_view alone
    task automatic strobe_view(input bit up);
        view_t cand;
        cand = next_view(exp_view, exp_mode, up);
        if (view_in_range(cand)) exp_view = cand;
        pulse(1'b0, up, !up);
    endtask

    task automatic build_expected(input view_t v);
        int x;
        int y;
        for (y = 0; y < FB_HEIGHT; y++) begin
            for (x = 0; x < FB_WIDTH; x++) begin
                ref_pix[y * FB_WIDTH + x] = escape_count(fp_t'(v.x_start + x * v.step),
                                                         fp_t'(v.y_start + y * v.step));
            end
        end
    endtask

    task automatic sweep_fb();
        int a;
        repeat (2) @(negedge clk_sys);  // last write lands after render_done
        for (a = 0; a < FB_PIXELS; a++) begin
            rd_addr  = fb_addr_t'(a);
            sweep_on = 1'b1;
            @(negedge clk_sys);
        end
        sweep_on = 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic check_render();
        bit ok;
        wait_busy(10, ok);
        assert (ok) else begin
            err_cnt++;
            $display("busy never rose after the render request at %0t", $time);
        end
        wait_done(ok);
        build_expected(exp_view);
        sweep_fb();
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark) test_fail++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_mark) ? "ok" : "FAILED");
        err_mark = err_cnt;
    endtask

    initial begin
        rst_sys   = 1'b1;
        btn_fire  = 1'b0;
        btn_up    = 1'b0;
        btn_dn    = 1'b0;
        rd_addr   = '0;
        sweep_on  = 1'b0;
        err_cnt   = 0;
        err_mark  = 0;
        test_cnt  = 0;
        test_fail = 0;
        seed      = 32'h2982_8711;
        exp_view  = '{x_start: X_START, y_start: Y_START, step: STEP_START};
        exp_mode  = PAN_X;
        repeat (3) @(negedge clk_sys);
        rst_sys = 1'b0;

        check_render();  // automatic after reset
        end_test("reset view render");

        repeat (3) fire_and_check();
        end_test("fire mode cycle");

        strobe_view(1'b0);  // PAN_X down
        check_render();
        fire_and_check();
        strobe_view(1'b1);  // PAN_Y up
        check_render();
        end_test("pan x and pan y");

        fire_and_check();   // into ZOOM
        strobe_view(1'b0);
        check_render();
        strobe_view(1'b1);
        check_render();
        end_test("zoom in and out");

        strobe_view(1'b1);  // step would pass STEP_START
        wait_busy(20, seen);
        assert (!seen) else begin
            err_cnt++;
            $display("a zoom out beyond the coarsest step started a render at %0t", $time);
        end
        sweep_fb();  // old picture still there
        end_test("zoom limit rejected");

        strobe_view(1'b0);
        wait_busy(10, seen);
        assert (seen) else begin
            err_cnt++;
            $display("busy never rose after the zoom in at %0t", $time);
        end
        for (k = 0; k < 6; k++) begin  // random strobes mid render
            wait_n = 1 + ($random(seed) & 15);
            repeat (wait_n) @(negedge clk_sys);
            if (busy) pulse(1'b0, wait_n[0], !wait_n[0]);
        end
        wait_done(seen);
        wait_busy(20, seen);
        assert (!seen) else begin
            err_cnt++;
            $display("a strobe sent while busy started another render at %0t", $time);
        end
        build_expected(exp_view);
        sweep_fb();
        end_test("strobes ignored while busy");

        $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+bench
design/mandel_pkg.sv
design/view_control.sv
design/pixel_scan.sv
design/mandel_iter.sv
design/framebuffer.sv
design/mandel_top.sv
bench/mandel_tb.sv
